// File: list.f
+incdir+include
hw/cpuPkg.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/cpuTop.sv
tb/tbClock.sv
tb/cpuTb.sv

// File: Makefile
# Verilator flow for the 8-bit core, override any variable on the command line

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --assert --timing
PASSTEXT  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: tb/cpuTb.sv
////////////////////////////////////////////////////////////
// 8-bit core testbench
// loads programs in reset, runs them against a reference
// model and checks every cycle's pc, writeback and store
////////////////////////////////////////////////////////////

`include "cpu_macros.svh"

module cpuTb;

	import cpuPkg::*;

	logic     clk;
	logic     rst;
	logic     progWe;
	pc_t      progAddr;
	instr_t   progData;
	pc_t      pc;
	logic     halted;
	logic     wbValid;
	regAddr_t wbReg;
	word_t    wbData;
	logic     storeValid;
	word_t    storeAddr;
	word_t    storeData;

	// reference model state
	instr_t modelImem [`CPU_IMEM_DEPTH];
	word_t  modelDmem [`CPU_DMEM_DEPTH];
	word_t  modelRegs [`CPU_NUM_REGS];
	pc_t    modelPc;

	instr_t      progQ [$];		// next program to load
	logic [15:0] lfsrState = 16'd9;
	opcode_t     randomOps [6] = '{opAdd, opNand, opSlt, opSltu, opSl, opSr};

	tbClock #(.period(20)) clock_inst (.clk);

	cpuTop cpuTop_inst (
		.clk, .rst, .progWe, .progAddr, .progData,
		.pc, .halted, .wbValid, .wbReg, .wbData,
		.storeValid, .storeAddr, .storeData
	);

	////////////////////////////////////////////////////////////
	// helpers and compare tasks
	////////////////////////////////////////////////////////////

	function automatic instr_t encodeInstr(logic [3:0] op, regAddr_t d, regAddr_t s, word_t im);
		return {op, d, s, im};	// op | rd | rs | imm8
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic word_t takeRandomBits(int n);
		word_t bits;
		logic  fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], fb};
			bits = {bits[6:0], fb};
		end
		return bits;
	endfunction

	task automatic stopOnError(string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
			stopOnError($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkPc(pc_t exp);
		if (pc !== exp)
			stopOnError($sformatf("Error: pc got 0x%h expected 0x%h", pc, exp));
	endtask

	task automatic checkWb(regAddr_t expReg, word_t expData);
		checkBit("wbValid", wbValid, 1'b1);
		if (wbReg !== expReg)
			stopOnError($sformatf("Error: wbReg got 0x%h expected 0x%h", wbReg, expReg));
		if (wbData !== expData)
			stopOnError($sformatf("Error: wbData got 0x%h expected 0x%h", wbData, expData));
	endtask

	task automatic checkStore(word_t expAddr, word_t expData);
		checkBit("storeValid", storeValid, 1'b1);
		if (storeAddr !== expAddr)
			stopOnError($sformatf("Error: storeAddr got 0x%h expected 0x%h", storeAddr, expAddr));
		if (storeData !== expData)
			stopOnError($sformatf("Error: storeData got 0x%h expected 0x%h", storeData, expData));
	endtask

	////////////////////////////////////////////////////////////
	// load, run and model
	////////////////////////////////////////////////////////////

	// reset 3 cycles, then write progQ while still in reset
	task automatic loadProgram();
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkPc('0);
		checkBit("wbValid", wbValid, 1'b0);
		checkBit("storeValid", storeValid, 1'b0);
		foreach (progQ[i]) begin
			@(posedge clk);
			progWe   <= 1'b1;
			progAddr <= pc_t'(i);
			progData <= progQ[i];
			modelImem[i] = progQ[i];
		end
		@(posedge clk);	// last word lands here
		progWe <= 1'b0;
		rst    <= 1'b0;
		modelPc = '0;
		for (int r = 0; r < `CPU_NUM_REGS; r++)
			modelRegs[r] = '0;
	endtask

	// one model step per cycle until halt, bounded by maxCycles
	task automatic runProgram(int maxCycles);
		instr_t   ins;
		opcode_t  op;
		regAddr_t d;
		word_t    a;
		word_t    b;
		word_t    im;
		word_t    res;
		word_t    addr;
		pc_t      nxt;
		logic     wr;
		logic     st;
		logic     done;
		int       cycles;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			@(negedge clk);
			if (cycles == maxCycles)
				stopOnError("timeout: the core never raised halted");
			cycles++;
			checkPc(modelPc);
			checkBit("halted", halted, 1'b0);
			ins  = modelImem[modelPc];
			op   = opcode_t'(ins[15:12]);
			d    = ins[11:10];
			a    = modelRegs[ins[11:10]];
			b    = modelRegs[ins[9:8]];
			im   = ins[7:0];
			addr = b + im;		// lw/sw address
			nxt  = modelPc + pc_t'(1);
			res  = '0;
			case (op)
				opAdd:  res = a + b;
				opNand: res = ~(a & b);
				opSlt:  res = ($signed(a) < $signed(b)) ? 8'd1 : 8'd0;
				opSltu: res = (a < b) ? 8'd1 : 8'd0;
				opSl:   res = a << b[2:0];
				opSr:   res = a >> b[2:0];
				opLw:   res = modelDmem[addr];
				opAddi: res = a + im;
				opJr:   nxt = pc_t'(b);
				opBeq:
					if (a == b)
						nxt = modelPc + pc_t'(1) + pc_t'(im);	// mod 64 wrap
				opJal: begin
					d   = regAddr_t'(`CPU_LINK_REG);
					res = {2'b00, nxt};	// pc + 1
					nxt = pc_t'(im);
				end
				opHalt: done = 1'b1;
				default: ;	// unused encodings do nothing
			endcase
			wr = op inside {opAdd, opNand, opSlt, opSltu, opSl, opSr, opLw, opAddi, opJal};
			st = (op == opSw);
			if (wr)
				checkWb(d, res);
			else
				checkBit("wbValid", wbValid, 1'b0);
			if (st)
				checkStore(addr, a);
			else
				checkBit("storeValid", storeValid, 1'b0);
			if (wr)
				modelRegs[d] = res;
			if (st)
				modelDmem[addr] = a;
			if (!done)
				modelPc = nxt;
		end
		@(negedge clk);
		checkBit("halted", halted, 1'b1);
		checkPc(modelPc);	// still on the halt word
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic exerciseAluOps();
		progQ.delete();
		progQ.push_back(encodeInstr(opAddi, 2'd0, 2'd0, 8'h85));	// negative
		progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'h7f));
		progQ.push_back(encodeInstr(opAdd, 2'd0, 2'd1, 8'h00));
		progQ.push_back(encodeInstr(opNand, 2'd0, 2'd1, 8'h00));
		progQ.push_back(encodeInstr(opAddi, 2'd2, 2'd0, 8'hf0));
		progQ.push_back(encodeInstr(opSlt, 2'd2, 2'd1, 8'h00));	// neg < pos
		progQ.push_back(encodeInstr(opAddi, 2'd2, 2'd0, 8'hf0));
		progQ.push_back(encodeInstr(opSltu, 2'd2, 2'd1, 8'h00));	// big unsigned
		progQ.push_back(encodeInstr(opAddi, 2'd3, 2'd0, 8'hfe));
		progQ.push_back(encodeInstr(opSlt, 2'd1, 2'd3, 8'h00));
		// r3 steps through all eight shift amounts
		for (int k = 0; k < 8; k++) begin
			progQ.push_back(encodeInstr(opAddi, 2'd0, 2'd0, 8'h5b));
			progQ.push_back(encodeInstr(opSl, 2'd0, 2'd3, 8'h00));
			progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'hc6));
			progQ.push_back(encodeInstr(opSr, 2'd1, 2'd3, 8'h00));
			progQ.push_back(encodeInstr(opAddi, 2'd3, 2'd0, 8'h01));
		end
		progQ.push_back(encodeInstr(opHalt, 2'd0, 2'd0, 8'h00));
		loadProgram();
		runProgram(200);
	endtask

	task automatic addiAndNops();
		progQ.delete();
		progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'h05));
		progQ.push_back(16'h1234);	// opcode 0001
		progQ.push_back(16'h3456);	// opcode 0011
		progQ.push_back(16'hd0ff);	// opcode 1101
		progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'hfb));	// wraps to 0
		progQ.push_back(encodeInstr(opHalt, 2'd0, 2'd0, 8'h00));
		loadProgram();
		runProgram(20);
	endtask

	task automatic storeThenLoad();
		progQ.delete();
		progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'h40));	// base
		progQ.push_back(encodeInstr(opAddi, 2'd2, 2'd0, 8'ha7));
		progQ.push_back(encodeInstr(opSw, 2'd2, 2'd1, 8'h05));	// mem[45]
		progQ.push_back(encodeInstr(opLw, 2'd0, 2'd1, 8'h05));
		progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'h02));
		progQ.push_back(encodeInstr(opLw, 2'd3, 2'd1, 8'h03));	// same byte
		progQ.push_back(encodeInstr(opHalt, 2'd0, 2'd0, 8'h00));
		loadProgram();
		runProgram(20);
	endtask

	task automatic branchAndJump();
		progQ.delete();
		progQ.push_back(encodeInstr(opAddi, 2'd0, 2'd0, 8'h02));	// loop limit
		progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'h01));	// loop top
		progQ.push_back(encodeInstr(opBeq, 2'd1, 2'd0, 8'h01));	// exit to 4
		progQ.push_back(encodeInstr(opBeq, 2'd2, 2'd2, 8'hfd));	// back to 1
		progQ.push_back(encodeInstr(opJal, 2'd0, 2'd0, 8'h07));
		progQ.push_back(encodeInstr(opAddi, 2'd2, 2'd0, 8'h09));	// return lands here
		progQ.push_back(encodeInstr(opHalt, 2'd0, 2'd0, 8'h00));
		progQ.push_back(encodeInstr(opAddi, 2'd1, 2'd0, 8'h0a));	// subroutine
		progQ.push_back(encodeInstr(opJr, 2'd0, 2'd3, 8'h00));
		loadProgram();
		runProgram(30);
	endtask

	task automatic haltThenReset();
		progQ.delete();
		progQ.push_back(encodeInstr(opAddi, 2'd0, 2'd0, 8'h11));
		progQ.push_back(encodeInstr(opAddi, 2'd3, 2'd0, 8'h22));
		progQ.push_back(encodeInstr(opHalt, 2'd0, 2'd0, 8'h00));
		progQ.push_back(encodeInstr(opSw, 2'd0, 2'd0, 8'h00));	// never reached
		loadProgram();
		runProgram(10);
		repeat (4) begin
			@(negedge clk);
			checkPc(modelPc);
			checkBit("halted", halted, 1'b1);
			checkBit("wbValid", wbValid, 1'b0);
			checkBit("storeValid", storeValid, 1'b0);
		end
		// reads of zero show the register file was cleared
		progQ.delete();
		for (int r = 0; r < `CPU_NUM_REGS; r++)
			progQ.push_back(encodeInstr(opAdd, regAddr_t'(r), regAddr_t'(r), 8'h00));
		progQ.push_back(encodeInstr(opHalt, 2'd0, 2'd0, 8'h00));
		loadProgram();
		runProgram(10);
	endtask

	task automatic randomAluProgram();
		logic [2:0] sel;
		regAddr_t   d;
		regAddr_t   s;
		progQ.delete();
		for (int r = 0; r < `CPU_NUM_REGS; r++)
			progQ.push_back(encodeInstr(opAddi, regAddr_t'(r), 2'd0, takeRandomBits(8)));
		for (int n = 0; n < 24; n++) begin
			sel = 3'(takeRandomBits(3));
			d   = regAddr_t'(takeRandomBits(2));
			s   = regAddr_t'(takeRandomBits(2));
			if (sel < 3'd6)
				progQ.push_back(encodeInstr(randomOps[sel], d, s, 8'h00));
			else
				progQ.push_back(encodeInstr(opAddi, d, s, takeRandomBits(8)));
		end
		progQ.push_back(encodeInstr(opHalt, 2'd0, 2'd0, 8'h00));
		loadProgram();
		runProgram(100);
	endtask

	initial begin
		rst      = 1'b1;
		progWe   = 1'b0;
		progAddr = '0;
		progData = '0;
		exerciseAluOps();
		addiAndNops();
		storeThenLoad();
		branchAndJump();
		haltThenReset();
		randomAluProgram();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: tb/tbClock.sv
////////////////////////////////////////////////////////////
// Testbench clock source, free running square wave
////////////////////////////////////////////////////////////

module tbClock #(
	parameter int period = 20	// time units per cycle
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(period / 2) clk = ~clk;	// 50% duty

endmodule

// File: hw/cpuTop.sv
////////////////////////////////////////////////////////////
// 8-bit single cycle core, top level
// decode, execute and result stages wired together
////////////////////////////////////////////////////////////

module cpuTop (
	input  logic             clk,
	input  logic             rst,
	input  logic             progWe,
	input  cpuPkg::pc_t      progAddr,
	input  cpuPkg::instr_t   progData,
	output cpuPkg::pc_t      pc,
	output logic             halted,
	output logic             wbValid,
	output cpuPkg::regAddr_t wbReg,
	output cpuPkg::word_t    wbData,
	output logic             storeValid,
	output cpuPkg::word_t    storeAddr,
	output cpuPkg::word_t    storeData
);

	import cpuPkg::*;

	// decode to execute/result
	regAddr_t rd;
	regAddr_t rs;
	word_t    imm;
	pc_t      pcPlusOne;
	aluOp_t   aluOp;
	logic     aluSrc;
	logic     memRead;
	logic     memWrite;
	logic     memToReg;
	logic     regWrite;
	logic     jctrl;
	logic     jrctrl;
	logic     branch;
	logic     linkWrite;

	// execute to decode/result
	word_t aluResult;
	word_t memAddr;
	pc_t   nextPc;

	// reg file read ports
	word_t rdData;
	word_t rsData;

	instrDecode decode_inst (
		.clk, .rst, .progWe, .progAddr, .progData, .nextPc,
		.pc, .halted, .rd, .rs, .imm, .pcPlusOne,
		.aluOp, .aluSrc, .memRead, .memWrite, .memToReg, .regWrite,
		.jctrl, .jrctrl, .branch, .linkWrite
	);

	aluExecute execute_inst (
		.rdData, .rsData, .imm, .aluOp, .aluSrc, .pcPlusOne,
		.jctrl, .jrctrl, .branch,
		.aluResult, .memAddr, .nextPc
	);

	resultStage result_inst (
		.clk, .rst, .rd, .rs, .regWrite, .linkWrite,
		.memRead, .memWrite, .memToReg, .halted,
		.aluResult, .memAddr, .pcPlusOne,
		.rdData, .rsData, .wbValid, .wbReg, .wbData,
		.storeValid, .storeAddr, .storeData
	);

endmodule

// File: hw/resultStage.sv
////////////////////////////////////////////////////////////
// Result stage
// register file, data memory, writeback select and the
// commit/observation outputs
////////////////////////////////////////////////////////////

`include "cpu_macros.svh"

module resultStage (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::regAddr_t rd,
	input  cpuPkg::regAddr_t rs,
	input  logic             regWrite,
	input  logic             linkWrite,	// jal
	input  logic             memRead,
	input  logic             memWrite,
	input  logic             memToReg,
	input  logic             halted,
	input  cpuPkg::word_t    aluResult,
	input  cpuPkg::word_t    memAddr,
	input  cpuPkg::pc_t      pcPlusOne,
	output cpuPkg::word_t    rdData,
	output cpuPkg::word_t    rsData,
	// observation, same cycle as the instruction
	output logic             wbValid,
	output cpuPkg::regAddr_t wbReg,
	output cpuPkg::word_t    wbData,
	output logic             storeValid,
	output cpuPkg::word_t    storeAddr,
	output cpuPkg::word_t    storeData
);

	import cpuPkg::*;

	word_t regFile [`CPU_NUM_REGS];
	word_t dmem [`CPU_DMEM_DEPTH];	// byte addressed, no reset
	word_t loadData;
	logic  commitEn;

	////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////

	assign rdData = regFile[rd];
	assign rsData = regFile[rs];

	assign loadData = memRead ? dmem[memAddr] : '0;

	////////////////////////////////////////////////////////////
	// writeback select
	////////////////////////////////////////////////////////////

	// nothing commits while loading a program or after halt
	assign commitEn = !halted && !rst;

	assign wbReg  = linkWrite ? regAddr_t'(`CPU_LINK_REG) : rd;
	assign wbData = linkWrite ? word_t'(pcPlusOne) :	// return address
		memToReg ? loadData : aluResult;
	assign wbValid = (regWrite || linkWrite) && commitEn;

	assign storeValid = memWrite && commitEn;
	assign storeAddr  = memAddr;
	assign storeData  = rdData;		// sw stores rd

	////////////////////////////////////////////////////////////
	// commits
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regFile[i] <= '0;
		end else if (wbValid) begin
			regFile[wbReg] <= wbData;
		end
	end

	always_ff @(posedge clk) begin
		if (storeValid)
			dmem[storeAddr] <= storeData;
	end

	// one data memory port, decode never asks for both
	memPortExclusive: assert property (@(posedge clk) disable iff (rst)
		!(memRead && memWrite))
		else $error("load and store decoded together");

endmodule

// File: hw/aluExecute.sv
////////////////////////////////////////////////////////////
// Execute stage
// operand select, alu, load/store address, branch compare
// and next pc choice
////////////////////////////////////////////////////////////

module aluExecute (
	input  cpuPkg::word_t  rdData,		// reg file port a
	input  cpuPkg::word_t  rsData,		// reg file port b
	input  cpuPkg::word_t  imm,
	input  cpuPkg::aluOp_t aluOp,
	input  logic           aluSrc,
	input  cpuPkg::pc_t    pcPlusOne,
	input  logic           jctrl,		// jal
	input  logic           jrctrl,		// jr
	input  logic           branch,		// beq
	output cpuPkg::word_t  aluResult,
	output cpuPkg::word_t  memAddr,
	output cpuPkg::pc_t    nextPc
);

	import cpuPkg::*;

	word_t opB;			// second alu operand
	logic  [2:0] shamt;		// shifts only use 0..7
	logic  zero;
	logic  branchTaken;
	pc_t   branchTarget;

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	assign opB   = aluSrc ? imm : rsData;
	assign shamt = opB[2:0];

	always_comb begin
		case (aluOp)
			aluAdd:  aluResult = rdData + opB;
			aluNand: aluResult = ~(rdData & opB);
			aluSlt:  aluResult = word_t'($signed(rdData) < $signed(opB));
			aluSltu: aluResult = word_t'(rdData < opB);
			aluShl:  aluResult = rdData << shamt;
			aluShr:  aluResult = rdData >> shamt;	// zero fill
			aluSub:  aluResult = rdData - opB;
			default: aluResult = '0;
		endcase
	end

	// lw/sw address, base register plus offset, wraps at 256
	assign memAddr = rsData + imm;

	////////////////////////////////////////////////////////////
	// next pc
	////////////////////////////////////////////////////////////

	assign zero        = (aluResult == '0);
	assign branchTaken = branch && zero;	// beq decodes sub, so zero means equal

	// offset is signed 8 bit, low six bits are enough mod 64
	assign branchTarget = pcPlusOne + pc_t'(imm);

	always_comb begin
		if (jrctrl)
			nextPc = pc_t'(rsData);		// jump register
		else if (jctrl)
			nextPc = pc_t'(imm);		// jal absolute target
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pcPlusOne;
	end

	// decode raises at most one jump kind, checked on any overlap
	jumpKindsExclusive: assert property (@(posedge (jctrl && jrctrl)) 1'b0)
		else $error("jal and jr decoded together");

endmodule

// File: hw/instrDecode.sv
////////////////////////////////////////////////////////////
// Fetch and control decode
// program load port, instruction memory, pc and halt state,
// opcode to control level decode
////////////////////////////////////////////////////////////

`include "cpu_macros.svh"

module instrDecode (
	input  logic            clk,
	input  logic            rst,
	// program load, only honoured during reset
	input  logic            progWe,
	input  cpuPkg::pc_t     progAddr,
	input  cpuPkg::instr_t  progData,
	input  cpuPkg::pc_t     nextPc,		// from execute
	// fetch state
	output cpuPkg::pc_t     pc,
	output logic            halted,
	// instruction fields
	output cpuPkg::regAddr_t rd,
	output cpuPkg::regAddr_t rs,
	output cpuPkg::word_t   imm,
	output cpuPkg::pc_t     pcPlusOne,
	// control levels
	output cpuPkg::aluOp_t  aluOp,
	output logic            aluSrc,
	output logic            memRead,
	output logic            memWrite,
	output logic            memToReg,
	output logic            regWrite,
	output logic            jctrl,
	output logic            jrctrl,
	output logic            branch,
	output logic            linkWrite
);

	import cpuPkg::*;

	instr_t  imem [`CPU_IMEM_DEPTH];	// program store
	instr_t  instr;			// word at pc
	opcode_t opcode;
	logic    isHalt;

	////////////////////////////////////////////////////////////
	// instruction memory
	////////////////////////////////////////////////////////////

	// written by the load port while the core sits in reset
	always_ff @(posedge clk) begin
		if (rst && progWe)
			imem[progAddr] <= progData;
	end

	assign instr  = imem[pc];	// async read, single cycle core
	assign opcode = opcode_t'(instr[15:12]);
	assign rd     = instr[11:10];
	assign rs     = instr[9:8];
	assign imm    = instr[7:0];

	assign pcPlusOne = pc + pc_t'(1);

	////////////////////////////////////////////////////////////
	// pc and halt
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			if (isHalt)
				halted <= 1'b1;	// pc stays on the halt word
			else
				pc <= nextPc;
		end
	end

	////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////

	always_comb begin
		// everything off unless the opcode asks for it
		aluOp     = aluAdd;
		aluSrc    = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		memToReg  = 1'b0;
		regWrite  = 1'b0;
		jctrl     = 1'b0;
		jrctrl    = 1'b0;
		branch    = 1'b0;
		linkWrite = 1'b0;
		isHalt    = 1'b0;
		case (opcode)
			opAdd: begin
				regWrite = 1'b1;
			end
			opNand: begin
				regWrite = 1'b1;
				aluOp    = aluNand;
			end
			opSlt: begin
				regWrite = 1'b1;
				aluOp    = aluSlt;
			end
			opSltu: begin
				regWrite = 1'b1;
				aluOp    = aluSltu;
			end
			opSl: begin
				regWrite = 1'b1;
				aluOp    = aluShl;
			end
			opSr: begin
				regWrite = 1'b1;
				aluOp    = aluShr;
			end
			opLw: begin
				regWrite = 1'b1;	// load result goes to rd
				memRead  = 1'b1;
				memToReg = 1'b1;
			end
			opSw:   memWrite = 1'b1;
			opAddi: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;	// imm as operand b
			end
			opJr:   jrctrl = 1'b1;
			opBeq: begin
				branch = 1'b1;
				aluOp  = aluSub;	// zero when rd == rs
			end
			opJal: begin
				jctrl     = 1'b1;
				linkWrite = 1'b1;	// return addr into link reg
			end
			opHalt: isHalt = 1'b1;
			default: ;	// unused encodings fall through as no-ops
		endcase
	end

	// loading only makes sense with the core parked
	progLoadInReset: assert property (@(posedge clk) !rst |-> !$rose(progWe))
		else $error("program write started outside reset");

endmodule

// File: hw/cpuPkg.sv
////////////////////////////////////////////////////////////
// 8-bit core shared types
// data/instr words, register index, pc, opcodes, alu ops
////////////////////////////////////////////////////////////

`include "cpu_macros.svh"

package cpuPkg;

	typedef logic [7:0]  word_t;	// datapath word
	typedef logic [15:0] instr_t;	// op | rd | rs | imm8
	typedef logic [1:0]  regAddr_t;	// one of four regs
	typedef logic [`CPU_PC_WIDTH-1:0] pc_t;

	// opcode field, bits 15..12
	// 0001, 0011, 1101 are left out on purpose and decode as no-ops
	typedef enum logic [3:0] {
		opAdd  = 4'b0000,
		opNand = 4'b0010,
		opSlt  = 4'b0100,	// signed compare
		opSltu = 4'b0101,	// unsigned compare
		opSl   = 4'b0110,
		opSr   = 4'b0111,	// logical, zero fill
		opLw   = 4'b1000,
		opSw   = 4'b1001,
		opAddi = 4'b1010,
		opJr   = 4'b1011,
		opBeq  = 4'b1100,
		opJal  = 4'b1110,
		opHalt = 4'b1111
	} opcode_t;

	// alu function select
	typedef enum logic [2:0] {
		aluAdd  = 3'b000,
		aluNand = 3'b001,
		aluSlt  = 3'b010,
		aluShl  = 3'b011,
		aluShr  = 3'b100,
		aluSltu = 3'b101,
		aluSub  = 3'b110	// beq equality via zero result
	} aluOp_t;

endpackage

// File: include/cpu_macros.svh
////////////////////////////////////////////////////////////
// 8-bit core sizing
// memory depths, pc width, register file size, link reg
////////////////////////////////////////////////////////////

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// instruction side
`define CPU_IMEM_DEPTH 64	// 16-bit words
`define CPU_PC_WIDTH   6	// log2 of imem depth

// data side
`define CPU_DMEM_DEPTH 256	// one byte per address, full 8-bit space

// register file
`define CPU_NUM_REGS   4
`define CPU_LINK_REG   3	// jal return address lands here

`endif
